// ==== source/pkt_loopback_settings.svh ====
`ifndef PKT_LOOPBACK_SETTINGS_SVH
`define PKT_LOOPBACK_SETTINGS_SVH

// ----------------------------------------------------------------------
// Beat layout
// ----------------------------------------------------------------------

// Payload word carried by each beat
`define DATA_W 64

// Unused bytes in the last beat of a frame
`define EMPTY_W 3

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------

// Entries per beat FIFO, power of two
`define FIFO_DEPTH 16

// Longest frame the transmit store can hold
`define MAX_BEATS 16

`endif

// ==== source/pkt_loopback_pkg.sv ====
`include "pkt_loopback_settings.svh"

package pkt_loopback_pkg;

    // ----------------------------------------------------------------------
    // Stream beat
    // ----------------------------------------------------------------------

    // Flags sit above the empty count and data word, 69 bits in all
    typedef struct packed {
        logic                sop;
        logic                eop;
        logic [`EMPTY_W-1:0] empty;
        logic [`DATA_W-1:0]  data;
    } beat_t;

    // Beat position inside a frame, wide enough to hold MAX_BEATS itself
    typedef logic [$clog2(`MAX_BEATS + 1)-1:0] beat_idx_t;

    // ----------------------------------------------------------------------
    // Transmit controller
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_send,
        st_done
    } tx_state_e;

endpackage

// ==== source/beat_fifo.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module beat_fifo import pkt_loopback_pkg::*; #(
    parameter int depth = `FIFO_DEPTH
) (
    input  logic  rd_clk,
    input  logic  rd_rst_n,

    input  logic  push,
    input  beat_t push_data,
    output logic  full,

    input  logic  pop,
    output beat_t pop_data,
    output logic  pop_valid,
    output logic  empty
);

    localparam int aw = $clog2(depth);
    localparam logic [aw:0] full_level = (aw + 1)'(depth);

    beat_t mem [depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_push;
    logic          do_pop;

    // Requests against a full or empty FIFO are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Flags come straight from the occupancy count
    assign empty = (count == '0);
    assign full  = (count == full_level);

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + aw'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + aw'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + (aw + 1)'(1);
                2'b01:   count <= count - (aw + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Storage and registered read port
    // ----------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    // A push while full loses a beat, on the rx side there is no ready to stop it
    a_no_push_full : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        !(push && full))
        else $error("beat_fifo: push while full, beat lost");

    // Readers are expected to watch empty before popping
    a_no_pop_empty : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        !(pop && empty))
        else $error("beat_fifo: pop while empty");

endmodule

// ==== source/payload_incrementer.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module payload_incrementer import pkt_loopback_pkg::*; (
    input  logic  rd_clk,
    input  logic  rd_rst_n,

    // Read side of the first FIFO
    input  beat_t in_data,
    input  logic  in_valid,
    input  logic  in_empty,
    output logic  in_pop,

    // Write side of the second FIFO
    output beat_t out_data,
    output logic  out_push,
    input  logic  out_full
);

    // Set from the pop until the modified beat has been pushed
    logic pending;

    // One read in flight at a time, so out_full is never stale when we push
    assign in_pop = !pending && !in_empty && !out_full;

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            pending  <= 1'b0;
            out_push <= 1'b0;
        end else begin
            out_push <= in_valid;
            if (in_pop) begin
                pending <= 1'b1;
            end else if (out_push) begin
                pending <= 1'b0;
            end
        end
    end

    // Framing fields pass through, data wraps modulo 2^DATA_W
    always_ff @(posedge rd_clk) begin
        if (in_valid) begin
            out_data      <= in_data;
            out_data.data <= in_data.data + `DATA_W'(1);
        end
    end

    // Full is checked at pop time two cycles earlier and must still hold
    a_push_not_full : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        out_push |-> !out_full)
        else $error("payload_incrementer: push into full FIFO");

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module frame_buffer import pkt_loopback_pkg::*; (
    input  logic      rd_clk,

    input  logic      wr_en,
    input  beat_idx_t wr_idx,
    input  beat_t     wr_beat,

    input  beat_idx_t rd_idx,
    output beat_t     rd_beat
);

    localparam int aw = $clog2(`MAX_BEATS);

    // One frame, loaded whole before it is sent
    beat_t mem [`MAX_BEATS];

    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem[wr_idx[aw-1:0]] <= wr_beat;
        end
    end

    // Combinational read so the beat follows the send index at once
    assign rd_beat = mem[rd_idx[aw-1:0]];

endmodule

// ==== source/tx_frame_ctrl.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module tx_frame_ctrl import pkt_loopback_pkg::*; (
    input  logic      rd_clk,
    input  logic      rd_rst_n,

    input  logic      link_up,

    // Second FIFO read side
    input  logic      fifo_empty,
    output logic      fifo_pop,
    input  beat_t     fifo_data,
    input  logic      fifo_valid,

    // Frame store
    output logic      buf_wr_en,
    output beat_idx_t buf_wr_idx,
    output beat_idx_t buf_rd_idx,
    input  beat_t     buf_rd_beat,

    // Transmit stream
    output logic      tx_valid,
    output beat_t     tx_beat,
    input  logic      tx_ready
);

    localparam beat_idx_t idx_one = beat_idx_t'(1);

    tx_state_e state;
    tx_state_e state_nxt;

    beat_idx_t load_idx;
    beat_idx_t frame_len;
    beat_idx_t send_idx;
    logic      last_beat;

    assign last_beat = (send_idx + idx_one) == frame_len;

    // ----------------------------------------------------------------------
    // State machine
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (link_up && !fifo_empty) begin
                    state_nxt = st_load;
                end
            end
            st_load: begin
                if (fifo_valid && fifo_data.eop) begin
                    state_nxt = st_send;
                end
            end
            st_send: begin
                if (tx_ready && last_beat) begin
                    state_nxt = st_done;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            state     <= st_idle;
            load_idx  <= '0;
            frame_len <= '0;
            send_idx  <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                st_idle: begin
                    load_idx  <= '0;
                    frame_len <= '0;
                    send_idx  <= '0;
                end
                st_load: begin
                    if (fifo_valid) begin
                        load_idx <= load_idx + idx_one;
                        // Length is known once the end beat lands
                        if (fifo_data.eop) begin
                            frame_len <= load_idx + idx_one;
                        end
                    end
                end
                st_send: begin
                    if (tx_ready) begin
                        send_idx <= send_idx + idx_one;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Load side
    // ----------------------------------------------------------------------

    // Single read in flight, so nothing past the end beat is pulled out
    assign fifo_pop   = (state == st_load) && !fifo_empty && !fifo_valid;
    assign buf_wr_en  = (state == st_load) && fifo_valid;
    assign buf_wr_idx = load_idx;

    // ----------------------------------------------------------------------
    // Send side
    // ----------------------------------------------------------------------
    assign buf_rd_idx = send_idx;
    assign tx_valid   = (state == st_send);

    // Framing taken from the counters rather than the stored flags
    always_comb begin
        tx_beat = '0;
        if (tx_valid) begin
            tx_beat.sop  = (send_idx == '0);
            tx_beat.eop  = last_beat;
            tx_beat.data = buf_rd_beat.data;
            if (last_beat) begin
                tx_beat.empty = buf_rd_beat.empty;
            end
        end
    end

    // Upstream frames must fit the store
    a_frame_fits : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        (state == st_load && fifo_valid) |-> (load_idx < beat_idx_t'(`MAX_BEATS)))
        else $error("tx_frame_ctrl: frame longer than MAX_BEATS");

endmodule

// ==== source/pkt_loopback_top.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module pkt_loopback_top import pkt_loopback_pkg::*; (
    input  logic  rd_clk,
    input  logic  rd_rst_n,

    input  logic  link_up,

    input  logic  rx_valid,
    input  beat_t rx_beat,

    output logic  tx_valid,
    output beat_t tx_beat,
    input  logic  tx_ready
);

    // rx FIFO to incrementer
    beat_t     rx_pop_data;
    logic      rx_pop;
    logic      rx_pop_valid;
    logic      rx_empty;

    // Incrementer to tx FIFO
    beat_t     tx_push_data;
    logic      tx_push;
    logic      tx_full;

    // tx FIFO to controller and frame store
    beat_t     tx_pop_data;
    logic      tx_pop;
    logic      tx_pop_valid;
    logic      tx_empty;

    // Controller to frame store
    logic      buf_wr_en;
    beat_idx_t buf_wr_idx;
    beat_idx_t buf_rd_idx;
    beat_t     buf_rd_beat;

    // ----------------------------------------------------------------------
    // Receive path
    // ----------------------------------------------------------------------

    // No ready toward the source, so full is left open
    beat_fifo #(
        .depth     (`FIFO_DEPTH)
    ) rx_fifo (
        .rd_clk    (rd_clk),
        .rd_rst_n  (rd_rst_n),
        .push      (rx_valid),
        .push_data (rx_beat),
        .full      (),
        .pop       (rx_pop),
        .pop_data  (rx_pop_data),
        .pop_valid (rx_pop_valid),
        .empty     (rx_empty)
    );

    payload_incrementer u_incrementer (
        .rd_clk    (rd_clk),
        .rd_rst_n  (rd_rst_n),
        .in_data   (rx_pop_data),
        .in_valid  (rx_pop_valid),
        .in_empty  (rx_empty),
        .in_pop    (rx_pop),
        .out_data  (tx_push_data),
        .out_push  (tx_push),
        .out_full  (tx_full)
    );

    beat_fifo #(
        .depth     (`FIFO_DEPTH)
    ) tx_fifo (
        .rd_clk    (rd_clk),
        .rd_rst_n  (rd_rst_n),
        .push      (tx_push),
        .push_data (tx_push_data),
        .full      (tx_full),
        .pop       (tx_pop),
        .pop_data  (tx_pop_data),
        .pop_valid (tx_pop_valid),
        .empty     (tx_empty)
    );

    // ----------------------------------------------------------------------
    // Transmit path
    // ----------------------------------------------------------------------
    frame_buffer u_frame_buffer (
        .rd_clk    (rd_clk),
        .wr_en     (buf_wr_en),
        .wr_idx    (buf_wr_idx),
        .wr_beat   (tx_pop_data),
        .rd_idx    (buf_rd_idx),
        .rd_beat   (buf_rd_beat)
    );

    tx_frame_ctrl u_tx_ctrl (
        .rd_clk      (rd_clk),
        .rd_rst_n    (rd_rst_n),
        .link_up     (link_up),
        .fifo_empty  (tx_empty),
        .fifo_pop    (tx_pop),
        .fifo_data   (tx_pop_data),
        .fifo_valid  (tx_pop_valid),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_idx  (buf_wr_idx),
        .buf_rd_idx  (buf_rd_idx),
        .buf_rd_beat (buf_rd_beat),
        .tx_valid    (tx_valid),
        .tx_beat     (tx_beat),
        .tx_ready    (tx_ready)
    );

endmodule

// ==== test/tb_pkt_loopback.sv ====
`timescale 1ns/1ns

`include "pkt_loopback_settings.svh"

module tb_pkt_loopback import pkt_loopback_pkg::*; ();

    localparam string cases_path = "test/pkt_loopback_cases.txt";

    logic  rd_clk;
    logic  rd_rst_n;
    logic  link_up;
    logic  rx_valid;
    beat_t rx_beat;
    logic  tx_valid;
    beat_t tx_beat;
    logic  tx_ready;

    // Cases as read from the file
    int    case_delay[$];
    logic  case_bp[$];
    int    case_len[$];
    beat_t in_beats[$];

    // Scoreboard and output monitor state
    beat_t       exp_q[$];
    logic        held;
    logic        bp_mode;
    logic [31:0] lfsr;
    int          cycle_count;
    int          cycle_limit;

    pkt_loopback_top dut (
        .rd_clk   (rd_clk),
        .rd_rst_n (rd_rst_n),
        .link_up  (link_up),
        .rx_valid (rx_valid),
        .rx_beat  (rx_beat),
        .tx_valid (tx_valid),
        .tx_beat  (tx_beat),
        .tx_ready (tx_ready)
    );

    initial begin
        rd_clk = 1'b0;
        forever #4 rd_clk = ~rd_clk;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input string what, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got sop=%b eop=%b empty=%0d data=%h", $time, what,
                     got.sop, got.eop, got.empty, got.data);
            $display("ERR %0t ns: %s expected sop=%b eop=%b empty=%0d data=%h", $time, what,
                     exp.sop, exp.eop, exp.empty, exp.data);
            stop_run();
        end
    endtask

    // No valid while the link is down, and an all-zero beat whenever valid is low
    task automatic check_idle(input logic valid, input beat_t beat, input logic link);
        if (!valid && beat !== '0) begin
            $display("ERR %0t ns: tx_beat is %h while tx_valid is low", $time, beat);
            stop_run();
        end
        if (!link && valid) begin
            $display("ERR %0t ns: tx_valid is high while link_up is low", $time);
            stop_run();
        end
    endtask

    task automatic read_cases();
        int                  fd;
        string               line;
        int                  delay;
        int                  bp;
        int                  eop;
        int                  empty;
        logic [`DATA_W-1:0]  data;
        beat_t               b;
        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", cases_path);
            stop_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.getc(0) == "C") begin
                if ($sscanf(line.substr(1, line.len() - 1), "%d %d", delay, bp) != 2) begin
                    $display("Malformed case line in the cases file: %s", line);
                    stop_run();
                end
                case_delay.push_back(delay);
                case_bp.push_back(bp != 0);
                case_len.push_back(0);
            end else if (line.getc(0) == "B") begin
                if (case_len.size() == 0 ||
                    $sscanf(line.substr(1, line.len() - 1), "%d %d %h", eop, empty, data) != 3)
                begin
                    $display("Malformed beat line in the cases file: %s", line);
                    stop_run();
                end
                b       = '0;
                b.eop   = (eop != 0);
                b.empty = `EMPTY_W'(empty);
                b.data  = data;
                in_beats.push_back(b);
                case_len[case_len.size() - 1]++;
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // Output monitor called once per falling edge
    // ----------------------------------------------------------------------
    task automatic observe_cycle();
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles: output stalled before all frames arrived",
                     cycle_count);
            stop_run();
        end
        // A beat refused last cycle must still be on offer
        if (held && !tx_valid) begin
            $display("ERR %0t ns: tx_valid dropped before the held beat left", $time);
            stop_run();
        end
        check_idle(tx_valid, tx_beat, link_up);
        // The beat on offer is the next expected one until it transfers
        if (tx_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERR %0t ns: output beat %h with no beat expected", $time, tx_beat);
                stop_run();
            end
            check_beat("output beat", tx_beat, exp_q[0]);
        end
        if (bp_mode) begin
            lfsr     = lfsr_next(lfsr);
            tx_ready = lfsr[0];
        end else begin
            tx_ready = 1'b1;
        end
        held = tx_valid && !tx_ready;
        if (tx_valid && tx_ready) begin
            exp_q.delete(0);
        end
    endtask

    task automatic next_cycle();
        @(negedge rd_clk);
        observe_cycle();
    endtask

    // Feed one case, raise the link after its delay, wait for every beat to leave
    task automatic run_case(input int delay, input logic bp, input int first, input int count);
        beat_t b;
        beat_t e;
        int    pos;
        pos = 0;
        next_cycle();
        link_up = (delay == 0);
        bp_mode = bp;
        for (int i = first; i < first + count; i++) begin
            b     = in_beats[i];
            b.sop = (pos == 0);
            // Framing follows position and empty stays only on the last beat
            e      = '0;
            e.sop  = b.sop;
            e.eop  = b.eop;
            e.data = b.data + `DATA_W'(1);
            if (b.eop) begin
                e.empty = b.empty;
            end
            exp_q.push_back(e);
            next_cycle();
            rx_valid = 1'b1;
            rx_beat  = b;
            pos      = b.eop ? 0 : pos + 1;
        end
        next_cycle();
        rx_valid = 1'b0;
        rx_beat  = '0;
        repeat (delay) next_cycle();
        link_up = 1'b1;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int first;
        rd_rst_n    = 1'b0;
        link_up     = 1'b0;
        rx_valid    = 1'b0;
        rx_beat     = '0;
        tx_ready    = 1'b0;
        bp_mode     = 1'b0;
        held        = 1'b0;
        lfsr        = 32'h1c9d_100e;
        cycle_count = 0;
        read_cases();
        cycle_limit = 200 + 20 * in_beats.size();
        repeat (8) @(posedge rd_clk);
        @(negedge rd_clk);
        rd_rst_n = 1'b1;
        first    = 0;
        for (int c = 0; c < case_len.size(); c++) begin
            run_case(case_delay[c], case_bp[c], first, case_len[c]);
            first += case_len[c];
        end
        repeat (4) next_cycle();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== test/pkt_loopback_cases.txt ====
# C <link_up delay in cycles> <random tx_ready, 0 or 1>
# B <eop> <empty> <data, 64-bit hex>, start of frame follows from position
C 0 0
B 0 0 0000000000000000
B 0 0 00000000000000ff
B 1 5 ffffffffffffffff
C 0 1
B 1 3 0123456789abcdef
B 0 0 fffffffffffffffe
B 0 6 1111111111111111
B 0 0 7fffffffffffffff
B 1 0 2222222222222222
C 40 0
B 0 0 a5a5a5a5a5a5a5a5
B 1 7 5a5a5a5a5a5a5a5a
B 1 1 0000000100000000
B 0 0 00000000ffffffff
B 1 2 0f1e2d3c4b5a6978
C 30 1
B 0 0 0000000000000010
B 0 0 0000000000000011
B 0 0 0000000000000012
B 0 0 0000000000000013
B 0 0 0000000000000014
B 1 4 0000000000000015
B 1 0 ffffffffffffffff

// ==== pkt_loopback_top.f ====
+incdir+source
source/pkt_loopback_pkg.sv
source/beat_fifo.sv
source/payload_incrementer.sv
source/frame_buffer.sv
source/tx_frame_ctrl.sv
source/pkt_loopback_top.sv
test/tb_pkt_loopback.sv

// ==== Makefile ====
TOP := tb_pkt_loopback
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f pkt_loopback_top.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module pkt_loopback_top -f pkt_loopback_top.f

clean:
	rm -rf obj_dir $(LOG)
